// File: verilog/tx_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Transmit chain package
// Sizes, AXI4-Lite register map and sample/frame types
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package tx_pkg;

  localparam int CHANNELS = 2;
  localparam int PARALLEL_SAMPLES = 2;
  localparam int SAMPLE_WIDTH = 16;
  localparam int SOURCES = 4;
  localparam int PHASE_BITS = 32;
  localparam int AWG_DEPTH = 32;
  localparam int SCALE_WIDTH = 18;
  localparam int SCALE_FRAC_BITS = 16;
  localparam int AXIL_ADDR_WIDTH = 12;
  localparam int AXIL_DATA_WIDTH = 32;

  // Derived widths
  localparam int AWG_ADDR_WIDTH = $clog2(AWG_DEPTH);
  localparam int SEL_WIDTH = $clog2(SOURCES);
  localparam int CHAN_WIDTH = $clog2(CHANNELS);
  localparam int PRODUCT_WIDTH = SAMPLE_WIDTH + SCALE_WIDTH;

  //////////////////////////////////////////////////////////////////////////
  // Register map, byte offsets
  //////////////////////////////////////////////////////////////////////////
  localparam logic [AXIL_ADDR_WIDTH-1:0] REG_CTRL     = 'h000;
  localparam logic [AXIL_ADDR_WIDTH-1:0] REG_TRI_INC0 = 'h004;
  localparam logic [AXIL_ADDR_WIDTH-1:0] REG_TRI_INC1 = 'h008;
  localparam logic [AXIL_ADDR_WIDTH-1:0] REG_MUX_SEL  = 'h00C;
  localparam logic [AXIL_ADDR_WIDTH-1:0] REG_SCALE0   = 'h010;
  localparam logic [AXIL_ADDR_WIDTH-1:0] REG_SCALE1   = 'h014;
  localparam logic [AXIL_ADDR_WIDTH-1:0] REG_OFFSET0  = 'h018;
  localparam logic [AXIL_ADDR_WIDTH-1:0] REG_OFFSET1  = 'h01C;
  localparam logic [AXIL_ADDR_WIDTH-1:0] REG_AWG_LEN0 = 'h020;
  localparam logic [AXIL_ADDR_WIDTH-1:0] REG_AWG_LEN1 = 'h024;
  // Channel 0 words at 0x100, channel 1 at 0x180
  localparam logic [AXIL_ADDR_WIDTH-1:0] AWG_BASE     = 'h100;

  typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;
  typedef logic signed [SCALE_WIDTH-1:0] scale_t;
  // Sample 0 is the earliest, in the low half
  typedef sample_t [PARALLEL_SAMPLES-1:0] frame_t;

  localparam scale_t SCALE_ONE = scale_t'(1) <<< SCALE_FRAC_BITS;
  localparam sample_t SAMPLE_MAX = {1'b0, {(SAMPLE_WIDTH-1){1'b1}}};
  localparam sample_t SAMPLE_MIN = {1'b1, {(SAMPLE_WIDTH-1){1'b0}}};

endpackage

`default_nettype wire

// File: verilog/cfg_if.sv
////////////////////////////////////////////////////////////////////////////
// Configuration bundle from the register block to the datapath
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

interface cfg_if;
  logic awg_en;
  logic tri_en;
  logic [tx_pkg::CHANNELS-1:0][tx_pkg::PHASE_BITS-1:0] tri_inc;
  logic [tx_pkg::CHANNELS-1:0][tx_pkg::SEL_WIDTH-1:0] mux_sel;
  tx_pkg::scale_t [tx_pkg::CHANNELS-1:0] scale;
  tx_pkg::sample_t [tx_pkg::CHANNELS-1:0] offset;
  logic [tx_pkg::CHANNELS-1:0][tx_pkg::AWG_ADDR_WIDTH-1:0] awg_len;

  // AWG memory write port, one-cycle strobe
  logic mem_we;
  logic [tx_pkg::CHAN_WIDTH-1:0] mem_chan;
  logic [tx_pkg::AWG_ADDR_WIDTH-1:0] mem_addr;
  tx_pkg::frame_t mem_wdata;

  modport master (output awg_en, tri_en, tri_inc, mux_sel, scale, offset, awg_len,
                  mem_we, mem_chan, mem_addr, mem_wdata);
  modport slave (input awg_en, tri_en, tri_inc, mux_sel, scale, offset, awg_len,
                 mem_we, mem_chan, mem_addr, mem_wdata);
endinterface

`default_nettype wire

// File: verilog/axil_config_regs.sv
////////////////////////////////////////////////////////////////////////////
// AXI4-Lite configuration slave
// Decodes the register map and forwards AWG memory writes
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module axil_config_regs (
  input  wire                                  dac_clk_i,
  input  wire                                  rst_i,
  input  wire [tx_pkg::AXIL_ADDR_WIDTH-1:0]    s_axil_awaddr_i,
  input  wire                                  s_axil_awvalid_i,
  output logic                                 s_axil_awready_o,
  input  wire [tx_pkg::AXIL_DATA_WIDTH-1:0]    s_axil_wdata_i,
  input  wire [tx_pkg::AXIL_DATA_WIDTH/8-1:0]  s_axil_wstrb_i,
  input  wire                                  s_axil_wvalid_i,
  output logic                                 s_axil_wready_o,
  output logic [1:0]                           s_axil_bresp_o,
  output logic                                 s_axil_bvalid_o,
  input  wire                                  s_axil_bready_i,
  input  wire [tx_pkg::AXIL_ADDR_WIDTH-1:0]    s_axil_araddr_i,
  input  wire                                  s_axil_arvalid_i,
  output logic                                 s_axil_arready_o,
  output logic [tx_pkg::AXIL_DATA_WIDTH-1:0]   s_axil_rdata_o,
  output logic [1:0]                           s_axil_rresp_o,
  output logic                                 s_axil_rvalid_o,
  input  wire                                  s_axil_rready_i,
  cfg_if.master                                cfg
);

  logic                                 aw_full;
  logic [tx_pkg::AXIL_ADDR_WIDTH-1:0]   aw_addr;
  logic                                 w_full;
  logic [tx_pkg::AXIL_DATA_WIDTH-1:0]   w_data;
  logic [tx_pkg::AXIL_DATA_WIDTH/8-1:0] w_strb;
  logic [tx_pkg::AXIL_DATA_WIDTH-1:0]   w_mask;
  logic [tx_pkg::AXIL_DATA_WIDTH-1:0]   w_merged;
  logic                                 do_write;
  logic                                 in_window;

  // Register contents as seen on the bus, zero for the memory window
  function automatic logic [tx_pkg::AXIL_DATA_WIDTH-1:0] reg_value(
    input logic [tx_pkg::AXIL_ADDR_WIDTH-1:0] addr
  );
    logic [tx_pkg::AXIL_DATA_WIDTH-1:0] v;
    v = '0;
    case (addr)
      tx_pkg::REG_CTRL:     v[1:0] = {cfg.tri_en, cfg.awg_en};
      tx_pkg::REG_TRI_INC0: v = cfg.tri_inc[0];
      tx_pkg::REG_TRI_INC1: v = cfg.tri_inc[1];
      tx_pkg::REG_MUX_SEL:  v[tx_pkg::CHANNELS*tx_pkg::SEL_WIDTH-1:0] = cfg.mux_sel;
      tx_pkg::REG_SCALE0:   v[tx_pkg::SCALE_WIDTH-1:0] = cfg.scale[0];
      tx_pkg::REG_SCALE1:   v[tx_pkg::SCALE_WIDTH-1:0] = cfg.scale[1];
      tx_pkg::REG_OFFSET0:  v[tx_pkg::SAMPLE_WIDTH-1:0] = cfg.offset[0];
      tx_pkg::REG_OFFSET1:  v[tx_pkg::SAMPLE_WIDTH-1:0] = cfg.offset[1];
      tx_pkg::REG_AWG_LEN0: v[tx_pkg::AWG_ADDR_WIDTH-1:0] = cfg.awg_len[0];
      tx_pkg::REG_AWG_LEN1: v[tx_pkg::AWG_ADDR_WIDTH-1:0] = cfg.awg_len[1];
      default:              v = '0;
    endcase
    return v;
  endfunction

  // Ready while the slot is empty and no response is pending
  assign s_axil_awready_o = !aw_full && !s_axil_bvalid_o;
  assign s_axil_wready_o  = !w_full && !s_axil_bvalid_o;
  assign s_axil_arready_o = !s_axil_rvalid_o;
  // Always OKAY
  assign s_axil_bresp_o = 2'b00;
  assign s_axil_rresp_o = 2'b00;

  assign do_write  = aw_full && w_full;
  assign in_window = aw_addr[tx_pkg::AXIL_ADDR_WIDTH-1:8] ==
                     tx_pkg::AWG_BASE[tx_pkg::AXIL_ADDR_WIDTH-1:8];

  // Byte strobes merged into the current register value
  always_comb begin
    for (int b = 0; b < tx_pkg::AXIL_DATA_WIDTH/8; b++) begin
      w_mask[8*b +: 8] = {8{w_strb[b]}};
    end
    w_merged = (reg_value(aw_addr) & ~w_mask) | (w_data & w_mask);
  end

  //////////////////////////////////////////////////////////////////////////
  // Handshake state and configuration registers
  //////////////////////////////////////////////////////////////////////////
  always_ff @(posedge dac_clk_i) begin
    if (rst_i) begin
      aw_full         <= 1'b0;
      w_full          <= 1'b0;
      s_axil_bvalid_o <= 1'b0;
      s_axil_rvalid_o <= 1'b0;
      cfg.mem_we      <= 1'b0;
      cfg.awg_en      <= 1'b0;
      cfg.tri_en      <= 1'b0;
      cfg.tri_inc     <= '0;
      cfg.offset      <= '0;
      cfg.awg_len     <= '0;
      for (int c = 0; c < tx_pkg::CHANNELS; c++) begin
        cfg.mux_sel[c] <= tx_pkg::SEL_WIDTH'(c);
        cfg.scale[c]   <= tx_pkg::SCALE_ONE;
      end
    end else begin
      cfg.mem_we <= 1'b0;
      if (s_axil_awvalid_i && s_axil_awready_o) aw_full <= 1'b1;
      if (s_axil_wvalid_i && s_axil_wready_o) w_full <= 1'b1;
      if (s_axil_bvalid_o && s_axil_bready_i) s_axil_bvalid_o <= 1'b0;
      if (do_write) begin
        aw_full         <= 1'b0;
        w_full          <= 1'b0;
        s_axil_bvalid_o <= 1'b1;
        if (in_window) begin
          cfg.mem_we <= 1'b1;
        end else begin
          case (aw_addr)
            tx_pkg::REG_CTRL: begin
              cfg.awg_en <= w_merged[0];
              cfg.tri_en <= w_merged[1];
            end
            tx_pkg::REG_TRI_INC0: cfg.tri_inc[0] <= w_merged;
            tx_pkg::REG_TRI_INC1: cfg.tri_inc[1] <= w_merged;
            tx_pkg::REG_MUX_SEL:
              cfg.mux_sel <= w_merged[tx_pkg::CHANNELS*tx_pkg::SEL_WIDTH-1:0];
            tx_pkg::REG_SCALE0:   cfg.scale[0] <= w_merged[tx_pkg::SCALE_WIDTH-1:0];
            tx_pkg::REG_SCALE1:   cfg.scale[1] <= w_merged[tx_pkg::SCALE_WIDTH-1:0];
            tx_pkg::REG_OFFSET0:  cfg.offset[0] <= w_merged[tx_pkg::SAMPLE_WIDTH-1:0];
            tx_pkg::REG_OFFSET1:  cfg.offset[1] <= w_merged[tx_pkg::SAMPLE_WIDTH-1:0];
            tx_pkg::REG_AWG_LEN0: cfg.awg_len[0] <= w_merged[tx_pkg::AWG_ADDR_WIDTH-1:0];
            tx_pkg::REG_AWG_LEN1: cfg.awg_len[1] <= w_merged[tx_pkg::AWG_ADDR_WIDTH-1:0];
            default: ;
          endcase
        end
      end
      if (s_axil_rvalid_o && s_axil_rready_i) s_axil_rvalid_o <= 1'b0;
      if (s_axil_arvalid_i && s_axil_arready_o) s_axil_rvalid_o <= 1'b1;
    end
  end

  // Slot and response payloads
  always_ff @(posedge dac_clk_i) begin
    if (s_axil_awvalid_i && s_axil_awready_o) aw_addr <= {s_axil_awaddr_i[11:2], 2'b00};
    if (s_axil_wvalid_i && s_axil_wready_o) begin
      w_data <= s_axil_wdata_i;
      w_strb <= s_axil_wstrb_i;
    end
    if (s_axil_arvalid_i && s_axil_arready_o) begin
      s_axil_rdata_o <= reg_value({s_axil_araddr_i[11:2], 2'b00});
    end
    // Word index in bits 6:2, channel above it
    cfg.mem_chan  <= aw_addr[2+tx_pkg::AWG_ADDR_WIDTH +: tx_pkg::CHAN_WIDTH];
    cfg.mem_addr  <= aw_addr[2 +: tx_pkg::AWG_ADDR_WIDTH];
    cfg.mem_wdata <= w_data;
  end

endmodule

`default_nettype wire

// File: verilog/awg_player.sv
////////////////////////////////////////////////////////////////////////////
// Arbitrary waveform player
// Loops each channel memory from word 0 to its programmed last word
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module awg_player (
  input  wire                                   dac_clk_i,
  input  wire                                   rst_i,
  cfg_if.slave                                  cfg,
  output tx_pkg::frame_t [tx_pkg::CHANNELS-1:0] awg_frame_o,
  output logic [tx_pkg::CHANNELS-1:0]           awg_valid_o
);

  tx_pkg::frame_t mem [tx_pkg::CHANNELS][tx_pkg::AWG_DEPTH];
  logic [tx_pkg::CHANNELS-1:0][tx_pkg::AWG_ADDR_WIDTH-1:0] word_addr;

  // Write port and registered read
  always_ff @(posedge dac_clk_i) begin
    if (cfg.mem_we) begin
      mem[cfg.mem_chan][cfg.mem_addr] <= cfg.mem_wdata;
    end
    for (int c = 0; c < tx_pkg::CHANNELS; c++) begin
      awg_frame_o[c] <= mem[c][word_addr[c]];
    end
  end

  // Address held at zero while disabled
  always_ff @(posedge dac_clk_i) begin
    if (rst_i) begin
      word_addr   <= '0;
      awg_valid_o <= '0;
    end else begin
      for (int c = 0; c < tx_pkg::CHANNELS; c++) begin
        awg_valid_o[c] <= cfg.awg_en;
        if (!cfg.awg_en || word_addr[c] == cfg.awg_len[c]) begin
          word_addr[c] <= '0;
        end else begin
          word_addr[c] <= word_addr[c] + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/tri_gen.sv
////////////////////////////////////////////////////////////////////////////
// Triangle generator, one phase accumulator per channel
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module tri_gen (
  input  wire                                   dac_clk_i,
  input  wire                                   rst_i,
  cfg_if.slave                                  cfg,
  output tx_pkg::frame_t [tx_pkg::CHANNELS-1:0] tri_frame_o,
  output logic [tx_pkg::CHANNELS-1:0]           tri_valid_o
);

  logic [tx_pkg::CHANNELS-1:0][tx_pkg::PHASE_BITS-1:0] phase;

  // Fold the upper half of the phase, then offset to two's complement
  function automatic tx_pkg::sample_t tri_sample(input logic [tx_pkg::PHASE_BITS-1:0] ph);
    logic [tx_pkg::SAMPLE_WIDTH-1:0] mag;
    mag = ph[tx_pkg::PHASE_BITS-2 -: tx_pkg::SAMPLE_WIDTH];
    if (ph[tx_pkg::PHASE_BITS-1]) mag = ~mag;
    return {~mag[tx_pkg::SAMPLE_WIDTH-1], mag[tx_pkg::SAMPLE_WIDTH-2:0]};
  endfunction

  always_ff @(posedge dac_clk_i) begin
    for (int c = 0; c < tx_pkg::CHANNELS; c++) begin
      for (int k = 0; k < tx_pkg::PARALLEL_SAMPLES; k++) begin
        tri_frame_o[c][k] <= tri_sample(phase[c] + tx_pkg::PHASE_BITS'(k) * cfg.tri_inc[c]);
      end
    end
  end

  // One frame of phase per cycle
  always_ff @(posedge dac_clk_i) begin
    if (rst_i) begin
      phase       <= '0;
      tri_valid_o <= '0;
    end else begin
      for (int c = 0; c < tx_pkg::CHANNELS; c++) begin
        tri_valid_o[c] <= cfg.tri_en;
        if (cfg.tri_en) begin
          phase[c] <= phase[c] +
                      tx_pkg::PHASE_BITS'(tx_pkg::PARALLEL_SAMPLES) * cfg.tri_inc[c];
        end else begin
          phase[c] <= '0;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/channel_mux.sv
////////////////////////////////////////////////////////////////////////////
// Source to DAC channel routing, one register stage
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module channel_mux (
  input  wire                                   dac_clk_i,
  input  wire                                   rst_i,
  cfg_if.slave                                  cfg,
  input  wire tx_pkg::frame_t [tx_pkg::SOURCES-1:0] src_frame_i,
  input  wire [tx_pkg::SOURCES-1:0]             src_valid_i,
  output tx_pkg::frame_t [tx_pkg::CHANNELS-1:0] mux_frame_o,
  output logic [tx_pkg::CHANNELS-1:0]           mux_valid_o
);

  always_ff @(posedge dac_clk_i) begin
    for (int c = 0; c < tx_pkg::CHANNELS; c++) begin
      mux_frame_o[c] <= src_frame_i[cfg.mux_sel[c]];
    end
  end

  always_ff @(posedge dac_clk_i) begin
    if (rst_i) begin
      mux_valid_o <= '0;
    end else begin
      for (int c = 0; c < tx_pkg::CHANNELS; c++) begin
        mux_valid_o[c] <= src_valid_i[cfg.mux_sel[c]];
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/dac_prescaler.sv
////////////////////////////////////////////////////////////////////////////
// DAC prescaler
// Signed scale and offset with saturation, two pipeline stages
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module dac_prescaler (
  input  wire                                   dac_clk_i,
  input  wire                                   rst_i,
  cfg_if.slave                                  cfg,
  input  wire tx_pkg::frame_t [tx_pkg::CHANNELS-1:0] pre_frame_i,
  input  wire [tx_pkg::CHANNELS-1:0]            pre_valid_i,
  output tx_pkg::frame_t [tx_pkg::CHANNELS-1:0] dac_frame_o,
  output logic [tx_pkg::CHANNELS-1:0]           dac_valid_o
);

  logic signed [tx_pkg::PRODUCT_WIDTH-1:0] product [tx_pkg::CHANNELS][tx_pkg::PARALLEL_SAMPLES];
  logic [tx_pkg::CHANNELS-1:0] product_valid;

  // Floor shift, offset, clip to the sample range
  function automatic tx_pkg::sample_t offset_sat(
    input logic signed [tx_pkg::PRODUCT_WIDTH-1:0] p,
    input tx_pkg::sample_t ofs
  );
    logic signed [tx_pkg::PRODUCT_WIDTH-1:0] sum;
    sum = (p >>> tx_pkg::SCALE_FRAC_BITS) + ofs;
    if (sum > tx_pkg::SAMPLE_MAX) return tx_pkg::SAMPLE_MAX;
    if (sum < tx_pkg::SAMPLE_MIN) return tx_pkg::SAMPLE_MIN;
    return sum[tx_pkg::SAMPLE_WIDTH-1:0];
  endfunction

  always_ff @(posedge dac_clk_i) begin
    for (int c = 0; c < tx_pkg::CHANNELS; c++) begin
      for (int k = 0; k < tx_pkg::PARALLEL_SAMPLES; k++) begin
        product[c][k]     <= pre_frame_i[c][k] * cfg.scale[c];
        dac_frame_o[c][k] <= offset_sat(product[c][k], cfg.offset[c]);
      end
    end
  end

  always_ff @(posedge dac_clk_i) begin
    if (rst_i) begin
      product_valid <= '0;
      dac_valid_o   <= '0;
    end else begin
      product_valid <= pre_valid_i;
      dac_valid_o   <= product_valid;
    end
  end

endmodule

`default_nettype wire

// File: verilog/transmit_top.sv
////////////////////////////////////////////////////////////////////////////
// Transmit chain top level
// AXI4-Lite config, AWG and triangle sources, channel mux, prescaler
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module transmit_top (
  input  wire                                   dac_clk_i,
  input  wire                                   rst_i,
  input  wire [tx_pkg::AXIL_ADDR_WIDTH-1:0]     s_axil_awaddr_i,
  input  wire                                   s_axil_awvalid_i,
  output logic                                  s_axil_awready_o,
  input  wire [tx_pkg::AXIL_DATA_WIDTH-1:0]     s_axil_wdata_i,
  input  wire [tx_pkg::AXIL_DATA_WIDTH/8-1:0]   s_axil_wstrb_i,
  input  wire                                   s_axil_wvalid_i,
  output logic                                  s_axil_wready_o,
  output logic [1:0]                            s_axil_bresp_o,
  output logic                                  s_axil_bvalid_o,
  input  wire                                   s_axil_bready_i,
  input  wire [tx_pkg::AXIL_ADDR_WIDTH-1:0]     s_axil_araddr_i,
  input  wire                                   s_axil_arvalid_i,
  output logic                                  s_axil_arready_o,
  output logic [tx_pkg::AXIL_DATA_WIDTH-1:0]    s_axil_rdata_o,
  output logic [1:0]                            s_axil_rresp_o,
  output logic                                  s_axil_rvalid_o,
  input  wire                                   s_axil_rready_i,
  // Realtime sample stream, channel 0 in the low frame
  output tx_pkg::frame_t [tx_pkg::CHANNELS-1:0] dac_data_o,
  output logic [tx_pkg::CHANNELS-1:0]           dac_valid_o
);

  cfg_if cfg ();

  tx_pkg::frame_t [tx_pkg::CHANNELS-1:0] awg_frame;
  tx_pkg::frame_t [tx_pkg::CHANNELS-1:0] tri_frame;
  tx_pkg::frame_t [tx_pkg::CHANNELS-1:0] mux_frame;
  tx_pkg::frame_t [tx_pkg::SOURCES-1:0]  src_frame;
  logic [tx_pkg::CHANNELS-1:0]           awg_valid;
  logic [tx_pkg::CHANNELS-1:0]           tri_valid;
  logic [tx_pkg::CHANNELS-1:0]           mux_valid;
  logic [tx_pkg::SOURCES-1:0]            src_valid;

  // AWG on sources 0 and 1, triangle on 2 and 3
  assign src_frame = {tri_frame, awg_frame};
  assign src_valid = {tri_valid, awg_valid};

  axil_config_regs config_regs_i (
    .dac_clk_i, .rst_i,
    .s_axil_awaddr_i, .s_axil_awvalid_i, .s_axil_awready_o,
    .s_axil_wdata_i, .s_axil_wstrb_i, .s_axil_wvalid_i, .s_axil_wready_o,
    .s_axil_bresp_o, .s_axil_bvalid_o, .s_axil_bready_i,
    .s_axil_araddr_i, .s_axil_arvalid_i, .s_axil_arready_o,
    .s_axil_rdata_o, .s_axil_rresp_o, .s_axil_rvalid_o, .s_axil_rready_i,
    .cfg(cfg.master)
  );

  awg_player awg_i (
    .dac_clk_i, .rst_i, .cfg(cfg.slave),
    .awg_frame_o(awg_frame), .awg_valid_o(awg_valid)
  );

  tri_gen tri_i (
    .dac_clk_i, .rst_i, .cfg(cfg.slave),
    .tri_frame_o(tri_frame), .tri_valid_o(tri_valid)
  );

  channel_mux channel_mux_i (
    .dac_clk_i, .rst_i, .cfg(cfg.slave),
    .src_frame_i(src_frame), .src_valid_i(src_valid),
    .mux_frame_o(mux_frame), .mux_valid_o(mux_valid)
  );

  dac_prescaler dac_prescaler_i (
    .dac_clk_i, .rst_i, .cfg(cfg.slave),
    .pre_frame_i(mux_frame), .pre_valid_i(mux_valid),
    .dac_frame_o(dac_data_o), .dac_valid_o(dac_valid_o)
  );

endmodule

`default_nettype wire

// File: bench/tx_model.svh
////////////////////////////////////////////////////////////////////////////
// Reference model of the transmit chain
// AWG playback, triangle rule, routing and prescaler arithmetic
////////////////////////////////////////////////////////////////////////////
`ifndef TX_MODEL_SVH
`define TX_MODEL_SVH

// Galois LFSR state, one step per random bit taken
logic [31:0] lfsr_state = 32'h99b0_3312;

// Model copies of the sample memories and configuration
logic [31:0] mem_model [tx_pkg::CHANNELS][tx_pkg::AWG_DEPTH];
logic [4:0]  awg_len_m [tx_pkg::CHANNELS];
logic [31:0] tri_inc_m [tx_pkg::CHANNELS];
logic [1:0]  sel_m     [tx_pkg::CHANNELS];
logic [17:0] scale_m   [tx_pkg::CHANNELS];
logic [15:0] offset_m  [tx_pkg::CHANNELS];

function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0000_0000);
endfunction

// Collects n bits, lowest first
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] r;
  r = '0;
  for (int i = 0; i < n; i++) begin
    r[i] = lfsr_state[0];
    lfsr_state = lfsr_next(lfsr_state);
  end
  return r;
endfunction

// Sample k of frame n, phase counted from zero
function automatic logic [15:0] tri_model(input logic [31:0] inc, input int n, input int k);
  logic [31:0] ph;
  logic [15:0] s;
  ph = inc * 32'(2 * n + k);
  s = ph[30:15];
  if (ph[31]) s = ~s;
  s[15] = ~s[15];
  return s;
endfunction

// Word index wraps after the last programmed word
function automatic logic [31:0] awg_model(input int c, input int n);
  return mem_model[c][n % (int'(awg_len_m[c]) + 1)];
endfunction

function automatic logic [31:0] source_model(input int src, input int n);
  if (src < 2) return awg_model(src, n);
  return {tri_model(tri_inc_m[src-2], n, 1), tri_model(tri_inc_m[src-2], n, 0)};
endfunction

// Floor of product over 65536, plus offset, clipped
function automatic logic [15:0] prescale_model(input logic [15:0] s, input logic [17:0] sc,
                                               input logic [15:0] ofs);
  longint p;
  p = longint'($signed(s)) * longint'($signed(sc));
  p = (p >>> 16) + longint'($signed(ofs));
  if (p > 32767) p = 32767;
  else if (p < -32768) p = -32768;
  return p[15:0];
endfunction

function automatic logic [15:0] expected_sample(input int c, input int n, input int k);
  logic [31:0] f;
  f = source_model(int'(sel_m[c]), n);
  return prescale_model(f[16*k +: 16], scale_m[c], offset_m[c]);
endfunction

`endif

// File: bench/tb_transmit_top.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the transmit chain
// Register access, AWG, triangle, routing and prescaler stream checks
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module tb_transmit_top;

  localparam int CLK_PERIOD = 10;
  localparam int FRAMES = 100;
  localparam int MUX_ROUNDS = 4;
  localparam int SCALE_ROUNDS = 6;
  localparam int STREAM_CHECKS = 3 + MUX_ROUNDS + SCALE_ROUNDS;
  localparam int BUS_OPS = 250;
  // About ten cycles per bus access plus lead-in per stream
  localparam int WATCHDOG_CYCLES = BUS_OPS * 10 + STREAM_CHECKS * (FRAMES + 20);

  logic clk;
  logic rst;
  logic [11:0] awaddr;
  logic awvalid;
  logic awready;
  logic [31:0] wdata;
  logic [3:0] wstrb;
  logic wvalid;
  logic wready;
  logic [1:0] bresp;
  logic bvalid;
  logic bready;
  logic [11:0] araddr;
  logic arvalid;
  logic arready;
  logic [31:0] rdata;
  logic [1:0] rresp;
  logic rvalid;
  logic rready;
  tx_pkg::frame_t [tx_pkg::CHANNELS-1:0] dac_data;
  logic [tx_pkg::CHANNELS-1:0] dac_valid;

  logic [31:0] rd;
  logic [31:0] data;
  logic [11:0] addr;
  logic [31:0] mask;
  logic [31:0] rst_val;
  logic [31:0] wr_exp [10];

  `include "tx_model.svh"

  transmit_top dut (
    .dac_clk_i(clk), .rst_i(rst),
    .s_axil_awaddr_i(awaddr), .s_axil_awvalid_i(awvalid), .s_axil_awready_o(awready),
    .s_axil_wdata_i(wdata), .s_axil_wstrb_i(wstrb), .s_axil_wvalid_i(wvalid),
    .s_axil_wready_o(wready), .s_axil_bresp_o(bresp), .s_axil_bvalid_o(bvalid),
    .s_axil_bready_i(bready), .s_axil_araddr_i(araddr), .s_axil_arvalid_i(arvalid),
    .s_axil_arready_o(arready), .s_axil_rdata_o(rdata), .s_axil_rresp_o(rresp),
    .s_axil_rvalid_o(rvalid), .s_axil_rready_i(rready),
    .dac_data_o(dac_data), .dac_valid_o(dac_valid)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(CLK_PERIOD * WATCHDOG_CYCLES);
    $display("Watchdog expired before the test sequence finished");
    $display("RESULT: FAIL");
    $fatal(1, "timeout");
  end

  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("ERROR at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      $display("RESULT: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // Address and data may be taken on different edges
  task automatic axil_write(input logic [11:0] a, input logic [31:0] d, input logic [3:0] s);
    logic aw_hs;
    logic w_hs;
    awaddr = a;
    wdata = d;
    wstrb = s;
    awvalid = 1'b1;
    wvalid = 1'b1;
    while (awvalid || wvalid) begin
      aw_hs = awvalid && awready;
      w_hs = wvalid && wready;
      @(posedge clk);
      #1;
      if (aw_hs) awvalid = 1'b0;
      if (w_hs) wvalid = 1'b0;
    end
    while (!bvalid) begin
      @(posedge clk);
      #1;
    end
    compare("s_axil_bresp_o", bresp, 64'h0);
    // Both slots stay closed while the response is pending
    compare("s_axil_awready_o", awready, 64'h0);
    compare("s_axil_wready_o", wready, 64'h0);
  endtask

  task automatic axil_read(input logic [11:0] a, output logic [31:0] d);
    logic ar_hs;
    araddr = a;
    arvalid = 1'b1;
    while (arvalid) begin
      ar_hs = arready;
      @(posedge clk);
      #1;
      if (ar_hs) arvalid = 1'b0;
    end
    while (!rvalid) begin
      @(posedge clk);
      #1;
    end
    d = rdata;
    compare("s_axil_rresp_o", rresp, 64'h0);
    compare("s_axil_arready_o", arready, 64'h0);
  endtask

  // Address, writable bits and reset value of register i
  task automatic reg_info(input int i, output logic [11:0] a, output logic [31:0] m,
                          output logic [31:0] r);
    case (i)
      0: a = tx_pkg::REG_CTRL;
      1: a = tx_pkg::REG_TRI_INC0;
      2: a = tx_pkg::REG_TRI_INC1;
      3: a = tx_pkg::REG_MUX_SEL;
      4: a = tx_pkg::REG_SCALE0;
      5: a = tx_pkg::REG_SCALE1;
      6: a = tx_pkg::REG_OFFSET0;
      7: a = tx_pkg::REG_OFFSET1;
      8: a = tx_pkg::REG_AWG_LEN0;
      default: a = tx_pkg::REG_AWG_LEN1;
    endcase
    case (i)
      0: m = 32'h3;
      3: m = 32'hF;
      4, 5: m = 32'h3_FFFF;
      6, 7: m = 32'hFFFF;
      8, 9: m = 32'h1F;
      default: m = 32'hFFFF_FFFF;
    endcase
    case (i)
      3: r = 32'h4;
      4, 5: r = 32'h1_0000;
      default: r = 32'h0;
    endcase
  endtask

  task automatic set_chain(input logic [1:0] sel0, input logic [1:0] sel1,
                           input logic [17:0] sc0, input logic [17:0] sc1,
                           input logic [15:0] of0, input logic [15:0] of1);
    sel_m[0] = sel0;
    sel_m[1] = sel1;
    scale_m[0] = sc0;
    scale_m[1] = sc1;
    offset_m[0] = of0;
    offset_m[1] = of1;
    axil_write(tx_pkg::REG_MUX_SEL, {28'h0, sel1, sel0}, 4'hF);
    axil_write(tx_pkg::REG_SCALE0, {14'h0, sc0}, 4'hF);
    axil_write(tx_pkg::REG_SCALE1, {14'h0, sc1}, 4'hF);
    axil_write(tx_pkg::REG_OFFSET0, {16'h0, of0}, 4'hF);
    axil_write(tx_pkg::REG_OFFSET1, {16'h0, of1}, 4'hF);
  endtask

  // Response handshake edge, then three cycles for valid to drain
  task automatic stop_sources();
    axil_write(tx_pkg::REG_CTRL, 32'h0, 4'hF);
    repeat (4) begin
      @(posedge clk);
      #1;
    end
    compare("dac_valid_o after disable", dac_valid, 64'h0);
  endtask

  // Frame index counts from the first valid output
  task automatic check_stream(input int frames);
    while (dac_valid !== 2'b11) begin
      @(posedge clk);
      #1;
    end
    for (int n = 0; n < frames; n++) begin
      compare("dac_valid_o", dac_valid, 64'h3);
      for (int c = 0; c < tx_pkg::CHANNELS; c++) begin
        for (int k = 0; k < tx_pkg::PARALLEL_SAMPLES; k++) begin
          compare($sformatf("dac_data_o[%0d][%0d] frame %0d", c, k, n),
                  $unsigned(dac_data[c][k]), expected_sample(c, n, k));
        end
      end
      @(posedge clk);
      #1;
    end
  endtask

  initial begin
    rst = 1'b1;
    awaddr = '0;
    awvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    wvalid = 1'b0;
    bready = 1'b1;
    araddr = '0;
    arvalid = 1'b0;
    rready = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;

    ////////////////////////////////////////////////////////////////////////////
    // Reset values and register readback
    ////////////////////////////////////////////////////////////////////////////
    compare("dac_valid_o", dac_valid, 64'h0);
    compare("s_axil_bvalid_o", bvalid, 64'h0);
    compare("s_axil_rvalid_o", rvalid, 64'h0);
    for (int i = 0; i < 10; i++) begin
      reg_info(i, addr, mask, rst_val);
      axil_read(addr, rd);
      compare($sformatf("register 0x%03h after reset", addr), rd, rst_val);
    end
    for (int i = 0; i < 10; i++) begin
      reg_info(i, addr, mask, rst_val);
      data = rand_bits(32);
      wr_exp[i] = data & mask;
      axil_write(addr, data, 4'hF);
    end
    for (int i = 0; i < 10; i++) begin
      reg_info(i, addr, mask, rst_val);
      axil_read(addr, rd);
      compare($sformatf("register 0x%03h", addr), rd, wr_exp[i]);
    end
    // Bytes 0 and 2 only
    axil_write(tx_pkg::REG_TRI_INC0, 32'hA5A5_A5A5, 4'b0101);
    axil_read(tx_pkg::REG_TRI_INC0, rd);
    compare("register 0x004 byte strobes", rd,
            (wr_exp[1] & 32'hFF00_FF00) | 32'h00A5_00A5);
    axil_read(tx_pkg::AWG_BASE, rd);
    compare("memory window 0x100", rd, 64'h0);
    axil_read(12'h1FC, rd);
    compare("memory window 0x1FC", rd, 64'h0);
    stop_sources();

    ////////////////////////////////////////////////////////////////////////////
    // AWG playback with default routing
    ////////////////////////////////////////////////////////////////////////////
    set_chain(2'd0, 2'd1, 18'h1_0000, 18'h1_0000, 16'h0, 16'h0);
    for (int c = 0; c < tx_pkg::CHANNELS; c++) begin
      for (int w = 0; w < tx_pkg::AWG_DEPTH; w++) begin
        mem_model[c][w] = rand_bits(32);
        axil_write(tx_pkg::AWG_BASE + 12'(c * 128 + w * 4), mem_model[c][w], 4'hF);
      end
      awg_len_m[c] = 5'(rand_bits(5));
    end
    axil_write(tx_pkg::REG_AWG_LEN0, {27'h0, awg_len_m[0]}, 4'hF);
    axil_write(tx_pkg::REG_AWG_LEN1, {27'h0, awg_len_m[1]}, 4'hF);
    axil_write(tx_pkg::REG_CTRL, 32'h1, 4'hF);
    check_stream(FRAMES);
    stop_sources();

    // Triangle only, routed to both outputs
    tri_inc_m[0] = rand_bits(32);
    tri_inc_m[1] = rand_bits(32);
    axil_write(tx_pkg::REG_TRI_INC0, tri_inc_m[0], 4'hF);
    axil_write(tx_pkg::REG_TRI_INC1, tri_inc_m[1], 4'hF);
    set_chain(2'd2, 2'd3, 18'h1_0000, 18'h1_0000, 16'h0, 16'h0);
    axil_write(tx_pkg::REG_CTRL, 32'h2, 4'hF);
    check_stream(FRAMES);
    stop_sources();

    // Random routing at unity gain
    for (int r = 0; r < MUX_ROUNDS; r++) begin
      set_chain(2'(rand_bits(2)), 2'(rand_bits(2)), 18'h1_0000, 18'h1_0000, 16'h0, 16'h0);
      axil_write(tx_pkg::REG_CTRL, 32'h3, 4'hF);
      check_stream(FRAMES);
      stop_sources();
    end

    ////////////////////////////////////////////////////////////////////////////
    // Scale, offset and clipping
    ////////////////////////////////////////////////////////////////////////////
    for (int r = 0; r < SCALE_ROUNDS; r++) begin
      if (r == 0) begin
        set_chain(2'd2, 2'd3, 18'h1_FFFF, 18'h1_FFFF, 16'h7FFF, 16'h7FFF);
      end else if (r == 1) begin
        set_chain(2'd0, 2'd3, 18'h1_FFFF, 18'h1_FFFF, 16'h8000, 16'h8000);
      end else begin
        set_chain(2'(rand_bits(2)), 2'(rand_bits(2)), 18'(rand_bits(18)),
                  18'(rand_bits(18)), 16'(rand_bits(16)), 16'(rand_bits(16)));
      end
      axil_write(tx_pkg::REG_CTRL, 32'h3, 4'hF);
      check_stream(FRAMES);
      stop_sources();
    end

    // Restart from word 0 and phase 0
    axil_write(tx_pkg::REG_CTRL, 32'h3, 4'hF);
    check_stream(FRAMES);
    stop_sources();

    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
+incdir+bench
verilog/tx_pkg.sv
verilog/cfg_if.sv
verilog/axil_config_regs.sv
verilog/awg_player.sv
verilog/tri_gen.sv
verilog/channel_mux.sv
verilog/dac_prescaler.sv
verilog/transmit_top.sv
bench/tb_transmit_top.sv

// File: Makefile
# Verilator build and run of the transmit chain testbench

VERILATOR ?= verilator
TOP       ?= tb_transmit_top
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

# Pass only when the simulator output holds the pass line
run: compile
	@out=$$(./$(BUILD_DIR)/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf $(BUILD_DIR)
